/* verilog/ex_macros.svh */
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// RV32I fixed widths
`define EX_XLEN       32  // data and address
`define EX_REG_ADDR_W 5   // register index
`define EX_STRB_W     4   // one strobe per byte lane

`endif

/* verilog/rv_isa_pkg.sv */
package rv_isa_pkg;

    // major opcodes handled by this stage
    parameter logic [6:0] OPC_OP_IMM = 7'b0010011;
    parameter logic [6:0] OPC_OP     = 7'b0110011;
    parameter logic [6:0] OPC_BRANCH = 7'b1100011;
    parameter logic [6:0] OPC_LOAD   = 7'b0000011;
    parameter logic [6:0] OPC_STORE  = 7'b0100011;

    // OP and OP-IMM
    parameter logic [2:0] F3_ADD_SUB = 3'b000;
    parameter logic [2:0] F3_SLL     = 3'b001;
    parameter logic [2:0] F3_SLT     = 3'b010;
    parameter logic [2:0] F3_SLTU    = 3'b011;
    parameter logic [2:0] F3_XOR     = 3'b100;
    parameter logic [2:0] F3_SRL_SRA = 3'b101;
    parameter logic [2:0] F3_OR      = 3'b110;
    parameter logic [2:0] F3_AND     = 3'b111;

    // branches
    parameter logic [2:0] F3_BEQ  = 3'b000;
    parameter logic [2:0] F3_BNE  = 3'b001;
    parameter logic [2:0] F3_BLT  = 3'b100;
    parameter logic [2:0] F3_BGE  = 3'b101;
    parameter logic [2:0] F3_BLTU = 3'b110;
    parameter logic [2:0] F3_BGEU = 3'b111;

    // loads
    parameter logic [2:0] F3_LB  = 3'b000;
    parameter logic [2:0] F3_LH  = 3'b001;
    parameter logic [2:0] F3_LW  = 3'b010;
    parameter logic [2:0] F3_LBU = 3'b100;
    parameter logic [2:0] F3_LHU = 3'b101;

    // stores
    parameter logic [2:0] F3_SB = 3'b000;
    parameter logic [2:0] F3_SH = 3'b001;
    parameter logic [2:0] F3_SW = 3'b010;

    parameter logic [6:0] F7_BASE = 7'b0000000;
    parameter logic [6:0] F7_ALT  = 7'b0100000;  // selects SUB and SRA

endpackage

/* verilog/ex_types_pkg.sv */
`include "ex_macros.svh"

package ex_types_pkg;

    typedef enum logic [2:0] {
        CLASS_NONE,    // bubble, nothing leaves the stage
        CLASS_ALU,
        CLASS_BRANCH,
        CLASS_LOAD,
        CLASS_STORE
    } op_class_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } branch_cond_e;

    typedef enum logic [1:0] {
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD
    } mem_size_e;

    // one memory word seen as byte lanes or as halfword lanes
    typedef union packed {
        logic [`EX_STRB_W-1:0][7:0]     byte_lane;
        logic [`EX_STRB_W/2-1:0][15:0]  half_lane;
    } mem_word_u;

endpackage

/* verilog/ex_decode.sv */
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_decode (
    input  logic [`EX_XLEN-1:0]         inst_i,
    output ex_types_pkg::op_class_e     class_o,
    output ex_types_pkg::alu_op_e       alu_op_o,
    output ex_types_pkg::branch_cond_e  branch_cond_o,
    output ex_types_pkg::mem_size_e     mem_size_o,
    output logic                        mem_unsigned_o,
    output logic                        wen_req_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_op;      // register form, funct7 is real
    logic       f7_base;
    logic       f7_alt;
    logic       alu_ok;

    assign opcode  = inst_i[6:0];
    assign funct3  = inst_i[14:12];
    assign funct7  = inst_i[31:25];
    assign is_op   = (opcode == rv_isa_pkg::OPC_OP);
    assign f7_base = (funct7 == rv_isa_pkg::F7_BASE);
    assign f7_alt  = (funct7 == rv_isa_pkg::F7_ALT);

    // ALU op and funct7 legality, shared by OP and OP-IMM
    always_comb begin
        alu_ok = !is_op || f7_base;   // immediate forms carry imm bits in funct7
        case (funct3)
            rv_isa_pkg::F3_ADD_SUB: begin
                alu_op_o = (is_op && f7_alt) ? ex_types_pkg::ALU_SUB : ex_types_pkg::ALU_ADD;
                alu_ok   = !is_op || f7_base || f7_alt;
            end
            rv_isa_pkg::F3_SLL: begin
                alu_op_o = ex_types_pkg::ALU_SLL;
                alu_ok   = f7_base;         // shamt upper bits must be zero
            end
            rv_isa_pkg::F3_SLT:  alu_op_o = ex_types_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU: alu_op_o = ex_types_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:  alu_op_o = ex_types_pkg::ALU_XOR;
            rv_isa_pkg::F3_SRL_SRA: begin
                alu_op_o = f7_alt ? ex_types_pkg::ALU_SRA : ex_types_pkg::ALU_SRL;
                alu_ok   = f7_base || f7_alt;
            end
            rv_isa_pkg::F3_OR:   alu_op_o = ex_types_pkg::ALU_OR;
            default:             alu_op_o = ex_types_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        class_o        = ex_types_pkg::CLASS_NONE;
        branch_cond_o  = ex_types_pkg::BR_EQ;
        mem_size_o     = ex_types_pkg::MEM_WORD;
        mem_unsigned_o = 1'b0;
        case (opcode)
            rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_OP: begin
                if (alu_ok)
                    class_o = ex_types_pkg::CLASS_ALU;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                class_o = ex_types_pkg::CLASS_BRANCH;
                case (funct3)
                    rv_isa_pkg::F3_BEQ:  branch_cond_o = ex_types_pkg::BR_EQ;
                    rv_isa_pkg::F3_BNE:  branch_cond_o = ex_types_pkg::BR_NE;
                    rv_isa_pkg::F3_BLT:  branch_cond_o = ex_types_pkg::BR_LT;
                    rv_isa_pkg::F3_BGE:  branch_cond_o = ex_types_pkg::BR_GE;
                    rv_isa_pkg::F3_BLTU: branch_cond_o = ex_types_pkg::BR_LTU;
                    rv_isa_pkg::F3_BGEU: branch_cond_o = ex_types_pkg::BR_GEU;
                    default:             class_o = ex_types_pkg::CLASS_NONE;
                endcase
            end
            rv_isa_pkg::OPC_LOAD: begin
                class_o        = ex_types_pkg::CLASS_LOAD;
                mem_unsigned_o = funct3[2];   // LBU and LHU
                case (funct3)
                    rv_isa_pkg::F3_LB, rv_isa_pkg::F3_LBU: mem_size_o = ex_types_pkg::MEM_BYTE;
                    rv_isa_pkg::F3_LH, rv_isa_pkg::F3_LHU: mem_size_o = ex_types_pkg::MEM_HALF;
                    rv_isa_pkg::F3_LW:                     mem_size_o = ex_types_pkg::MEM_WORD;
                    default:                               class_o = ex_types_pkg::CLASS_NONE;
                endcase
            end
            rv_isa_pkg::OPC_STORE: begin
                class_o = ex_types_pkg::CLASS_STORE;
                case (funct3)
                    rv_isa_pkg::F3_SB: mem_size_o = ex_types_pkg::MEM_BYTE;
                    rv_isa_pkg::F3_SH: mem_size_o = ex_types_pkg::MEM_HALF;
                    rv_isa_pkg::F3_SW: mem_size_o = ex_types_pkg::MEM_WORD;
                    default:           class_o = ex_types_pkg::CLASS_NONE;
                endcase
            end
            default: class_o = ex_types_pkg::CLASS_NONE;
        endcase
    end

    // only ALU ops and loads write rd
    assign wen_req_o = (class_o == ex_types_pkg::CLASS_ALU) ||
                       (class_o == ex_types_pkg::CLASS_LOAD);

endmodule

/* verilog/ex_alu.sv */
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_alu (
    input  logic [`EX_XLEN-1:0]     op_num1_i,
    input  logic [`EX_XLEN-1:0]     op_num2_i,
    input  ex_types_pkg::alu_op_e   alu_op_i,
    output logic [`EX_XLEN-1:0]     result_o,
    output logic                    eq_o,
    output logic                    lt_signed_o,
    output logic                    lt_unsigned_o
);

    logic                   sub_en;
    logic [`EX_XLEN-1:0]    add_b;
    logic [`EX_XLEN-1:0]    sum;
    logic [4:0]             shamt;
    logic [`EX_XLEN-1:0]    shl;
    logic [`EX_XLEN-1:0]    shr;
    logic [`EX_XLEN-1:0]    sra_mask;
    logic [`EX_XLEN-1:0]    sra;

    // one adder for ADD and SUB, two's complement via inverted operand and carry in
    assign sub_en = (alu_op_i == ex_types_pkg::ALU_SUB);
    assign add_b  = sub_en ? ~op_num2_i : op_num2_i;
    assign sum    = op_num1_i + add_b + {{(`EX_XLEN-1){1'b0}}, sub_en};

    // comparisons stay valid for every op, branches use them too
    assign eq_o          = (op_num1_i == op_num2_i);
    assign lt_signed_o   = ($signed(op_num1_i) < $signed(op_num2_i));
    assign lt_unsigned_o = (op_num1_i < op_num2_i);

    assign shamt    = op_num2_i[4:0];
    assign shl      = op_num1_i << shamt;
    assign shr      = op_num1_i >> shamt;
    assign sra_mask = {`EX_XLEN{1'b1}} >> shamt;
    assign sra      = (shr & sra_mask) | ({`EX_XLEN{op_num1_i[`EX_XLEN-1]}} & ~sra_mask);

    always_comb begin
        case (alu_op_i)
            ex_types_pkg::ALU_ADD,
            ex_types_pkg::ALU_SUB:  result_o = sum;
            ex_types_pkg::ALU_SLL:  result_o = shl;
            ex_types_pkg::ALU_SLT:  result_o = {{(`EX_XLEN-1){1'b0}}, lt_signed_o};
            ex_types_pkg::ALU_SLTU: result_o = {{(`EX_XLEN-1){1'b0}}, lt_unsigned_o};
            ex_types_pkg::ALU_XOR:  result_o = op_num1_i ^ op_num2_i;
            ex_types_pkg::ALU_SRL:  result_o = shr;
            ex_types_pkg::ALU_SRA:  result_o = sra;
            ex_types_pkg::ALU_OR:   result_o = op_num1_i | op_num2_i;
            default:                result_o = op_num1_i & op_num2_i;
        endcase
    end

endmodule

/* verilog/ex_lsu.sv */
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_lsu (
    input  logic [`EX_XLEN-1:0]     base_addr_i,
    input  logic [`EX_XLEN-1:0]     addr_offset_i,
    input  logic [`EX_XLEN-1:0]     store_src_i,
    input  logic [`EX_XLEN-1:0]     mem_rd_data_i,
    input  ex_types_pkg::mem_size_e mem_size_i,
    input  logic                    mem_unsigned_i,
    output logic [`EX_XLEN-1:0]     eff_addr_o,
    output logic [`EX_XLEN-1:0]     store_data_o,
    output logic [`EX_STRB_W-1:0]   store_strb_o,
    output logic [`EX_XLEN-1:0]     load_result_o
);

    logic [1:0]                 lane;
    ex_types_pkg::mem_word_u    st_word;
    ex_types_pkg::mem_word_u    rd_word;
    logic [7:0]                 rd_byte;
    logic [15:0]                rd_half;

    assign eff_addr_o = base_addr_i + addr_offset_i;  // also the branch target
    assign lane       = eff_addr_o[1:0];

    // little endian, low byte at the low address
    always_comb begin
        st_word = '0;
        case (mem_size_i)
            ex_types_pkg::MEM_BYTE: begin
                st_word.byte_lane[lane] = store_src_i[7:0];
                store_strb_o            = `EX_STRB_W'(1) << lane;
            end
            ex_types_pkg::MEM_HALF: begin
                st_word.half_lane[lane[1]] = store_src_i[15:0];
                store_strb_o               = lane[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                st_word      = store_src_i;
                store_strb_o = {`EX_STRB_W{1'b1}};
            end
        endcase
    end

    assign store_data_o = st_word;

    assign rd_word = mem_rd_data_i;
    assign rd_byte = rd_word.byte_lane[lane];
    assign rd_half = rd_word.half_lane[lane[1]];   // bit 0 ignored, no misalign trap

    always_comb begin
        case (mem_size_i)
            ex_types_pkg::MEM_BYTE: begin
                if (mem_unsigned_i)
                    load_result_o = {{(`EX_XLEN-8){1'b0}}, rd_byte};
                else
                    load_result_o = {{(`EX_XLEN-8){rd_byte[7]}}, rd_byte};
            end
            ex_types_pkg::MEM_HALF: begin
                if (mem_unsigned_i)
                    load_result_o = {{(`EX_XLEN-16){1'b0}}, rd_half};
                else
                    load_result_o = {{(`EX_XLEN-16){rd_half[15]}}, rd_half};
            end
            default: load_result_o = rd_word;
        endcase
    end

endmodule

/* verilog/ex_commit.sv */
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_commit (
    input  logic                        clk,
    input  logic                        rst_i,
    input  ex_types_pkg::op_class_e     class_i,
    input  ex_types_pkg::branch_cond_e  branch_cond_i,
    input  logic                        wen_req_i,
    input  logic [`EX_REG_ADDR_W-1:0]   rd_addr_i,
    input  logic [`EX_XLEN-1:0]         alu_result_i,
    input  logic [`EX_XLEN-1:0]         load_result_i,
    input  logic [`EX_XLEN-1:0]         eff_addr_i,
    input  logic [`EX_XLEN-1:0]         store_data_i,
    input  logic [`EX_STRB_W-1:0]       store_strb_i,
    input  logic                        eq_i,
    input  logic                        lt_signed_i,
    input  logic                        lt_unsigned_i,
    output logic [`EX_REG_ADDR_W-1:0]   rd_addr_o,
    output logic [`EX_XLEN-1:0]         rd_data_o,
    output logic                        rd_wen_o,
    output logic [`EX_XLEN-1:0]         jump_addr_o,
    output logic                        jump_en_o,
    output logic                        mem_wr_req_o,
    output logic [`EX_STRB_W-1:0]       mem_wr_sel_o,
    output logic [`EX_XLEN-1:0]         mem_wr_addr_o,
    output logic [`EX_XLEN-1:0]         mem_wr_data_o
);

    logic                   is_branch;
    logic                   is_store;
    logic                   taken;
    logic [`EX_XLEN-1:0]    wb_data;

    assign is_branch = (class_i == ex_types_pkg::CLASS_BRANCH);
    assign is_store  = (class_i == ex_types_pkg::CLASS_STORE);
    assign wb_data   = (class_i == ex_types_pkg::CLASS_LOAD) ? load_result_i : alu_result_i;

    // GE forms are the negated LT flags
    always_comb begin
        case (branch_cond_i)
            ex_types_pkg::BR_EQ:  taken = eq_i;
            ex_types_pkg::BR_NE:  taken = ~eq_i;
            ex_types_pkg::BR_LT:  taken = lt_signed_i;
            ex_types_pkg::BR_GE:  taken = ~lt_signed_i;
            ex_types_pkg::BR_LTU: taken = lt_unsigned_i;
            ex_types_pkg::BR_GEU: taken = ~lt_unsigned_i;
            default:              taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rd_addr_o     <= '0;
            rd_data_o     <= '0;
            rd_wen_o      <= 1'b0;
            jump_addr_o   <= '0;
            jump_en_o     <= 1'b0;
            mem_wr_req_o  <= 1'b0;
            mem_wr_sel_o  <= '0;
            mem_wr_addr_o <= '0;
            mem_wr_data_o <= '0;
        end else begin
            rd_wen_o      <= wen_req_i;
            rd_addr_o     <= wen_req_i ? rd_addr_i : '0;
            rd_data_o     <= wen_req_i ? wb_data : '0;
            jump_en_o     <= is_branch & taken;
            jump_addr_o   <= is_branch ? eff_addr_i : '0;   // target kept even if not taken
            mem_wr_req_o  <= is_store;
            mem_wr_sel_o  <= is_store ? store_strb_i : '0;
            mem_wr_addr_o <= is_store ? eff_addr_i : '0;
            mem_wr_data_o <= is_store ? store_data_i : '0;
        end
    end

endmodule

/* verilog/ex_top.sv */
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_top (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic [`EX_XLEN-1:0]         inst_i,
    input  logic [`EX_XLEN-1:0]         op_num1_i,
    input  logic [`EX_XLEN-1:0]         op_num2_i,
    input  logic [`EX_REG_ADDR_W-1:0]   rd_addr_i,
    input  logic [`EX_XLEN-1:0]         base_addr_i,
    input  logic [`EX_XLEN-1:0]         addr_offset_i,
    input  logic [`EX_XLEN-1:0]         mem_rd_data_i,
    output logic [`EX_REG_ADDR_W-1:0]   rd_addr_o,
    output logic [`EX_XLEN-1:0]         rd_data_o,
    output logic                        rd_wen_o,
    output logic [`EX_XLEN-1:0]         jump_addr_o,
    output logic                        jump_en_o,
    output logic                        mem_wr_req_o,
    output logic [`EX_STRB_W-1:0]       mem_wr_sel_o,
    output logic [`EX_XLEN-1:0]         mem_wr_addr_o,
    output logic [`EX_XLEN-1:0]         mem_wr_data_o
);

    ex_types_pkg::op_class_e    op_class;
    ex_types_pkg::alu_op_e      alu_op;
    ex_types_pkg::branch_cond_e branch_cond;
    ex_types_pkg::mem_size_e    mem_size;
    logic                       mem_unsigned;
    logic                       wen_req;
    logic [`EX_XLEN-1:0]        alu_result;
    logic                       eq;
    logic                       lt_signed;
    logic                       lt_unsigned;
    logic [`EX_XLEN-1:0]        eff_addr;
    logic [`EX_XLEN-1:0]        store_data;
    logic [`EX_STRB_W-1:0]      store_strb;
    logic [`EX_XLEN-1:0]        load_result;

    ex_decode u_decode (
        .inst_i         (inst_i),
        .class_o        (op_class),
        .alu_op_o       (alu_op),
        .branch_cond_o  (branch_cond),
        .mem_size_o     (mem_size),
        .mem_unsigned_o (mem_unsigned),
        .wen_req_o      (wen_req)
    );

    ex_alu u_alu (
        .op_num1_i      (op_num1_i),
        .op_num2_i      (op_num2_i),
        .alu_op_i       (alu_op),
        .result_o       (alu_result),
        .eq_o           (eq),
        .lt_signed_o    (lt_signed),
        .lt_unsigned_o  (lt_unsigned)
    );

    // op_num2 carries rs2 for stores
    ex_lsu u_lsu (
        .base_addr_i    (base_addr_i),
        .addr_offset_i  (addr_offset_i),
        .store_src_i    (op_num2_i),
        .mem_rd_data_i  (mem_rd_data_i),
        .mem_size_i     (mem_size),
        .mem_unsigned_i (mem_unsigned),
        .eff_addr_o     (eff_addr),
        .store_data_o   (store_data),
        .store_strb_o   (store_strb),
        .load_result_o  (load_result)
    );

    ex_commit u_commit (
        .clk            (clk),
        .rst_i          (rst_i),
        .class_i        (op_class),
        .branch_cond_i  (branch_cond),
        .wen_req_i      (wen_req),
        .rd_addr_i      (rd_addr_i),
        .alu_result_i   (alu_result),
        .load_result_i  (load_result),
        .eff_addr_i     (eff_addr),
        .store_data_i   (store_data),
        .store_strb_i   (store_strb),
        .eq_i           (eq),
        .lt_signed_i    (lt_signed),
        .lt_unsigned_i  (lt_unsigned),
        .rd_addr_o      (rd_addr_o),
        .rd_data_o      (rd_data_o),
        .rd_wen_o       (rd_wen_o),
        .jump_addr_o    (jump_addr_o),
        .jump_en_o      (jump_en_o),
        .mem_wr_req_o   (mem_wr_req_o),
        .mem_wr_sel_o   (mem_wr_sel_o),
        .mem_wr_addr_o  (mem_wr_addr_o),
        .mem_wr_data_o  (mem_wr_data_o)
    );

endmodule

/* verif/tb_ex_top.sv */
`timescale 1ns/1ps
`include "ex_macros.svh"

module tb_ex_top;

    localparam int CLK_PERIOD  = 8;
    // reset + alu + bad funct7 + shifts + branches + loads + stores + flush
    localparam int NUM_VECTORS = 4 + 152 + 8 + 96 + 48 + 40 + 24 + 2;
    localparam int TIMEOUT_NS  = (NUM_VECTORS + 16) * CLK_PERIOD;

    // OP forms first, then OP-IMM forms
    localparam logic [2:0] ALU_F3 [19] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6,
        3'd7, 3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
    localparam logic [31:0] BR_A [6] = '{32'd5, 32'd3, 32'd9, 32'hffff_fffc, 32'd7, 32'h8000_0000};
    localparam logic [31:0] BR_B [6] = '{32'd5, 32'd9, 32'd3, 32'd7, 32'hffff_fffc, 32'h7fff_ffff};

    logic                       clk = 1'b0;
    logic                       rst_i;
    logic [`EX_XLEN-1:0]        inst_i, op_num1_i, op_num2_i, base_addr_i, addr_offset_i;
    logic [`EX_XLEN-1:0]        mem_rd_data_i;
    logic [`EX_REG_ADDR_W-1:0]  rd_addr_i, rd_addr_o, exp_rd_addr;
    logic [`EX_XLEN-1:0]        rd_data_o, jump_addr_o, mem_wr_addr_o, mem_wr_data_o;
    logic [`EX_XLEN-1:0]        exp_rd_data, exp_jump_addr, exp_mem_addr, exp_mem_data;
    logic                       rd_wen_o, jump_en_o, mem_wr_req_o;
    logic                       exp_rd_wen, exp_jump_en, exp_mem_req;
    logic [`EX_STRB_W-1:0]      mem_wr_sel_o, exp_mem_sel;
    logic                       model_valid = 1'b0;
    integer                     seed;
    int                         checks = 0;
    int                         errors = 0;

    always #(CLK_PERIOD/2) clk = ~clk;

    ex_top i_dut (
        .clk(clk), .rst_i(rst_i), .inst_i(inst_i), .op_num1_i(op_num1_i), .op_num2_i(op_num2_i),
        .rd_addr_i(rd_addr_i), .base_addr_i(base_addr_i), .addr_offset_i(addr_offset_i),
        .mem_rd_data_i(mem_rd_data_i), .rd_addr_o(rd_addr_o), .rd_data_o(rd_data_o),
        .rd_wen_o(rd_wen_o), .jump_addr_o(jump_addr_o), .jump_en_o(jump_en_o),
        .mem_wr_req_o(mem_wr_req_o), .mem_wr_sel_o(mem_wr_sel_o),
        .mem_wr_addr_o(mem_wr_addr_o), .mem_wr_data_o(mem_wr_data_o)
    );

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    // random rs1 and rd fields
    function automatic logic [31:0] make_inst(input logic [6:0] f7, input logic [4:0] rs2,
                                              input logic [2:0] f3, input logic [6:0] opc);
        logic [31:0] r;
        r = rand_word();
        return {f7, rs2, r[4:0], f3, r[9:5], opc};
    endfunction

    task automatic drive(input logic [31:0] inst, input logic [31:0] a, input logic [31:0] b,
                         input logic [31:0] base, input logic [31:0] off,
                         input logic [31:0] rdata);
        @(posedge clk);
        #1;
        inst_i        = inst;
        rd_addr_i     = inst[11:7];
        op_num1_i     = a;
        op_num2_i     = b;
        base_addr_i   = base;
        addr_offset_i = off;
        mem_rd_data_i = rdata;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        checks++;
        assert (act_v === exp_v) else begin
            errors++;
            $display("ERROR %0t ns %s expected %h actual %h", $time, name, exp_v, act_v);
        end
    endtask

    // expected outputs of the instruction sampled at this edge
    always @(posedge clk) begin : ref_model
        logic [6:0]         opc;
        logic [2:0]         f3;
        logic [6:0]         f7;
        logic               is_reg;
        logic               valid;
        logic               taken;
        logic [31:0]        a;
        logic [31:0]        b;
        logic [31:0]        ea;
        logic [31:0]        byte_sel;
        logic [31:0]        half_sel;
        logic signed [31:0] a_signed;
        logic               n_wen;
        logic [31:0]        n_data;
        logic               n_mreq;
        logic [3:0]         n_msel;
        logic [31:0]        n_mdata;
        opc      = inst_i[6:0];
        f3       = inst_i[14:12];
        f7       = inst_i[31:25];
        a        = op_num1_i;
        b        = op_num2_i;
        a_signed = op_num1_i;
        ea       = base_addr_i + addr_offset_i;
        byte_sel = mem_rd_data_i >> {ea[1:0], 3'b000};
        half_sel = mem_rd_data_i >> {ea[1], 4'b0000};
        is_reg   = (opc == rv_isa_pkg::OPC_OP);
        valid    = 1'b0;
        taken    = 1'b0;
        n_wen    = 1'b0;
        n_data   = '0;
        n_mreq   = 1'b0;
        n_msel   = '0;
        n_mdata  = '0;
        case (rst_i ? 7'h00 : opc)
            rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_OP: begin
                n_wen = !is_reg || (f7 == rv_isa_pkg::F7_BASE);
                case (f3)
                    3'd0: begin
                        n_wen  = n_wen || (is_reg && f7 == rv_isa_pkg::F7_ALT);
                        n_data = (is_reg && f7 == rv_isa_pkg::F7_ALT) ? a - b : a + b;
                    end
                    3'd1: begin
                        n_wen  = (f7 == rv_isa_pkg::F7_BASE);  // slli has no alt form
                        n_data = a << b[4:0];
                    end
                    3'd2: n_data = {31'b0, (a_signed < $signed(b))};
                    3'd3: n_data = {31'b0, (a < b)};
                    3'd4: n_data = a ^ b;
                    3'd6: n_data = a | b;
                    3'd7: n_data = a & b;
                    default: begin
                        n_wen = (f7 == rv_isa_pkg::F7_BASE) || (f7 == rv_isa_pkg::F7_ALT);
                        if (f7 == rv_isa_pkg::F7_ALT)
                            n_data = a_signed >>> b[4:0];
                        else
                            n_data = a >> b[4:0];
                    end
                endcase
            end
            rv_isa_pkg::OPC_BRANCH: begin
                valid = 1'b1;
                case (f3)
                    rv_isa_pkg::F3_BEQ:  taken = (a == b);
                    rv_isa_pkg::F3_BNE:  taken = (a != b);
                    rv_isa_pkg::F3_BLT:  taken = (a_signed < $signed(b));
                    rv_isa_pkg::F3_BGE:  taken = (a_signed >= $signed(b));
                    rv_isa_pkg::F3_BLTU: taken = (a < b);
                    rv_isa_pkg::F3_BGEU: taken = (a >= b);
                    default:             valid = 1'b0;
                endcase
            end
            rv_isa_pkg::OPC_LOAD: begin
                n_wen = 1'b1;
                case (f3)
                    rv_isa_pkg::F3_LB:  n_data = {{24{byte_sel[7]}}, byte_sel[7:0]};
                    rv_isa_pkg::F3_LBU: n_data = {24'b0, byte_sel[7:0]};
                    rv_isa_pkg::F3_LH:  n_data = {{16{half_sel[15]}}, half_sel[15:0]};
                    rv_isa_pkg::F3_LHU: n_data = {16'b0, half_sel[15:0]};
                    rv_isa_pkg::F3_LW:  n_data = mem_rd_data_i;
                    default:            n_wen = 1'b0;
                endcase
            end
            rv_isa_pkg::OPC_STORE: begin
                n_mreq = 1'b1;
                case (f3)
                    rv_isa_pkg::F3_SB: begin
                        n_msel  = 4'b0001 << ea[1:0];
                        n_mdata = {24'b0, b[7:0]} << {ea[1:0], 3'b000};
                    end
                    rv_isa_pkg::F3_SH: begin
                        n_msel  = ea[1] ? 4'b1100 : 4'b0011;
                        n_mdata = {16'b0, b[15:0]} << {ea[1], 4'b0000};
                    end
                    rv_isa_pkg::F3_SW: begin
                        n_msel  = 4'b1111;
                        n_mdata = b;
                    end
                    default: n_mreq = 1'b0;
                endcase
            end
            default: ;
        endcase
        exp_rd_wen    <= n_wen;
        exp_rd_addr   <= n_wen ? rd_addr_i : '0;
        exp_rd_data   <= n_wen ? n_data : '0;
        exp_jump_en   <= valid && taken;
        exp_jump_addr <= valid ? ea : '0;   // target even when not taken
        exp_mem_req   <= n_mreq;
        exp_mem_sel   <= n_msel;
        exp_mem_addr  <= n_mreq ? ea : '0;
        exp_mem_data  <= n_mdata;
        model_valid   <= 1'b1;
    end

    // outputs settled since the rising edge
    always @(negedge clk) begin
        if (model_valid) begin
            check_value("rd_wen_o", {31'b0, exp_rd_wen}, {31'b0, rd_wen_o});
            check_value("rd_addr_o", {27'b0, exp_rd_addr}, {27'b0, rd_addr_o});
            check_value("rd_data_o", exp_rd_data, rd_data_o);
            check_value("jump_en_o", {31'b0, exp_jump_en}, {31'b0, jump_en_o});
            check_value("jump_addr_o", exp_jump_addr, jump_addr_o);
            check_value("mem_wr_req_o", {31'b0, exp_mem_req}, {31'b0, mem_wr_req_o});
            check_value("mem_wr_sel_o", {28'b0, exp_mem_sel}, {28'b0, mem_wr_sel_o});
            check_value("mem_wr_addr_o", exp_mem_addr, mem_wr_addr_o);
            check_value("mem_wr_data_o", exp_mem_data, mem_wr_data_o);
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, stimulus never completed", TIMEOUT_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] inst;
        logic [6:0]  f7;
        logic [2:0]  f3;
        seed          = 32'h9be302c5;
        rst_i         = 1'b1;
        inst_i        = '0;
        rd_addr_i     = '0;
        op_num1_i     = '0;
        op_num2_i     = '0;
        base_addr_i   = '0;
        addr_offset_i = '0;
        mem_rd_data_i = '0;
        repeat (3) @(posedge clk);
        #1 rst_i = 1'b0;   // next edge sees a zero instruction

        for (int op = 0; op < 19; op++) begin
            for (int n = 0; n < 8; n++) begin
                r  = rand_word();
                f3 = ALU_F3[op];
                f7 = (op == 1 || op == 7 || op == 18) ? rv_isa_pkg::F7_ALT : rv_isa_pkg::F7_BASE;
                if (op < 10) begin
                    b    = rand_word();
                    inst = make_inst(f7, r[4:0], f3, rv_isa_pkg::OPC_OP);
                end else begin
                    if (f3 == rv_isa_pkg::F3_SLL || f3 == rv_isa_pkg::F3_SRL_SRA)
                        b = {20'b0, f7, r[4:0]};
                    else
                        b = {{20{r[11]}}, r[11:0]};
                    inst = make_inst(b[11:5], b[4:0], f3, rv_isa_pkg::OPC_OP_IMM);
                end
                drive(inst, rand_word(), b, rand_word(), rand_word(), rand_word());
            end
        end
        // funct7 codes that are neither base nor alt
        for (int n = 0; n < 4; n++) begin
            drive(make_inst(7'h01, 5'd3, rv_isa_pkg::F3_ADD_SUB, rv_isa_pkg::OPC_OP),
                  rand_word(), rand_word(), rand_word(), rand_word(), rand_word());
            drive(make_inst(7'h10, 5'd3, rv_isa_pkg::F3_SRL_SRA, rv_isa_pkg::OPC_OP),
                  rand_word(), rand_word(), rand_word(), rand_word(), rand_word());
        end

        for (int sh = 0; sh < 32; sh++) begin
            a = rand_word() | 32'h8000_0000;
            r = rand_word();
            b = {r[31:5], sh[4:0]};
            drive(make_inst(rv_isa_pkg::F7_ALT, b[4:0], rv_isa_pkg::F3_SRL_SRA,
                  rv_isa_pkg::OPC_OP), a, b, r, r, r);
            drive(make_inst(rv_isa_pkg::F7_ALT, b[4:0], rv_isa_pkg::F3_SRL_SRA,
                  rv_isa_pkg::OPC_OP_IMM), a, {20'b0, rv_isa_pkg::F7_ALT, b[4:0]}, r, r, r);
            drive(make_inst(rv_isa_pkg::F7_BASE, b[4:0], rv_isa_pkg::F3_SRL_SRA,
                  rv_isa_pkg::OPC_OP), a, b, r, r, r);
        end

        // all eight funct3 values with two undefined for branches
        for (int c = 0; c < 8; c++)
            for (int p = 0; p < 6; p++)
                drive(make_inst(7'h2a, 5'd7, c[2:0], rv_isa_pkg::OPC_BRANCH),
                      BR_A[p], BR_B[p], rand_word(), rand_word(), rand_word());

        for (int rnd = 0; rnd < 2; rnd++)
            for (int i = 0; i < 5; i++)
                for (int ln = 0; ln < 4; ln++) begin
                    f3 = (i == 0) ? rv_isa_pkg::F3_LB : (i == 1) ? rv_isa_pkg::F3_LH :
                         (i == 2) ? rv_isa_pkg::F3_LW : (i == 3) ? rv_isa_pkg::F3_LBU :
                         rv_isa_pkg::F3_LHU;
                    b = (rnd == 0) ? (rand_word() | 32'h8080_8080) : (rand_word() & 32'h7f7f_7f7f);
                    drive(make_inst(7'h00, 5'd0, f3, rv_isa_pkg::OPC_LOAD), rand_word(),
                          rand_word(), rand_word() & 32'hffff_fffc,
                          (rand_word() & 32'h0000_0ffc) | {30'b0, ln[1:0]}, b);
                end

        for (int rnd = 0; rnd < 2; rnd++)
            for (int i = 0; i < 3; i++)
                for (int ln = 0; ln < 4; ln++) begin
                    f3 = (i == 0) ? rv_isa_pkg::F3_SB : (i == 1) ? rv_isa_pkg::F3_SH :
                         rv_isa_pkg::F3_SW;
                    drive(make_inst(7'h00, 5'd9, f3, rv_isa_pkg::OPC_STORE), rand_word(),
                          rand_word(), rand_word() & 32'hffff_fffc,
                          (rand_word() & 32'h0000_0ffc) | {30'b0, ln[1:0]}, rand_word());
                end

        drive('0, '0, '0, '0, '0, '0);
        drive('0, '0, '0, '0, '0, '0);
        @(negedge clk);
        @(negedge clk);
        #1;   // last compare has run
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/ex_types_pkg.sv
verilog/ex_decode.sv
verilog/ex_alu.sv
verilog/ex_lsu.sv
verilog/ex_commit.sv
verilog/ex_top.sv
verif/tb_ex_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ex_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

.PHONY: all compile run check clean

all: check

compile:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)

check: run
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "no pass line found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
